//--- rtl/rp_analog_pkg.sv
// analog chain shared definitions
package rp_analog_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // converter sample width
  localparam int unsigned SAMPLE_W = 14;
  // gain word, Q2.14 style
  localparam int unsigned GAIN_W = 16;
  localparam int unsigned GAIN_FRAC = 14;
  // slow analog outputs
  localparam int unsigned PDM_W = 8;
  // register bus
  localparam int unsigned AXIL_ADDR_W = 8;
  localparam int unsigned AXIL_DATA_W = 32;

  ////////////////////////////////////////////////////////////
  // sample and config types
  ////////////////////////////////////////////////////////////

  typedef logic signed [SAMPLE_W-1:0] adc_sample_t;
  typedef logic signed [SAMPLE_W-1:0] dac_sample_t;

  // per channel calibration
  typedef struct packed {
    logic signed [GAIN_W-1:0]   gain;
    logic signed [SAMPLE_W-1:0] offset;
  } calib_cfg_t;

  typedef logic [PDM_W-1:0] pdm_val_t;

  // unity gain at reset
  localparam logic signed [GAIN_W-1:0] GAIN_ONE = GAIN_W'(16384);

  ////////////////////////////////////////////////////////////
  // AXI4-Lite
  ////////////////////////////////////////////////////////////

  // master side
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [AXIL_DATA_W-1:0] wdata;
    logic                   wvalid;
    logic                   bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  // slave side
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

  // register byte offsets, channel n at +4n
  localparam logic [AXIL_ADDR_W-1:0] REG_CTRL     = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_ADC_GAIN = 8'h04;
  localparam logic [AXIL_ADDR_W-1:0] REG_ADC_OFFS = 8'h0C;
  localparam logic [AXIL_ADDR_W-1:0] REG_DAC_GAIN = 8'h14;
  localparam logic [AXIL_ADDR_W-1:0] REG_DAC_OFFS = 8'h1C;
  localparam logic [AXIL_ADDR_W-1:0] REG_PDM      = 8'h24;

endpackage

//--- rtl/axil_cfg_regs.sv
// AXI4-Lite configuration registers
`timescale 1ns/1ns

module axil_cfg_regs #(
  parameter int unsigned NUM_CH  = 2,
  parameter int unsigned PDM_CHN = 4
) (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  input  rp_analog_pkg::axil_req_t                 req_i,
  output rp_analog_pkg::axil_rsp_t                 rsp_o,
  output rp_analog_pkg::calib_cfg_t [NUM_CH-1:0]   adc_cfg_o,
  output rp_analog_pkg::calib_cfg_t [NUM_CH-1:0]   dac_cfg_o,
  output logic                                     loop_o,
  output rp_analog_pkg::pdm_val_t   [PDM_CHN-1:0]  pdm_val_o
);

  localparam int unsigned AW = rp_analog_pkg::AXIL_ADDR_W;
  localparam int unsigned DW = rp_analog_pkg::AXIL_DATA_W;

  // byte address of channel idx in a register array
  function automatic logic [AW-1:0] ch_addr(input logic [AW-1:0] base, input int unsigned idx);
    return base + AW'(4 * idx);
  endfunction

  // handshake state
  logic          aw_rdy_q;
  logic          bvalid_q;
  logic          ar_rdy_q;
  logic          rvalid_q;
  logic [DW-1:0] rdata_q;
  logic [DW-1:0] rd_mux;
  logic          wr_en;
  logic          rd_en;

  // transfer accepted this cycle
  assign wr_en = aw_rdy_q & req_i.awvalid & req_i.wvalid;
  assign rd_en = ar_rdy_q & req_i.arvalid;

  ////////////////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      aw_rdy_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      loop_o    <= 1'b0;
      adc_cfg_o <= '{default: '{gain: rp_analog_pkg::GAIN_ONE, offset: '0}};
      dac_cfg_o <= '{default: '{gain: rp_analog_pkg::GAIN_ONE, offset: '0}};
      pdm_val_o <= '0;
    end else begin
      // single cycle ready, blocked while response waits
      aw_rdy_q <= req_i.awvalid & req_i.wvalid & ~bvalid_q & ~aw_rdy_q;
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (wr_en) begin
        // unmapped addresses fall through
        if (req_i.awaddr == rp_analog_pkg::REG_CTRL) begin
          loop_o <= req_i.wdata[0];
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
          if (req_i.awaddr == ch_addr(rp_analog_pkg::REG_ADC_GAIN, ch)) begin
            adc_cfg_o[ch].gain <= req_i.wdata[rp_analog_pkg::GAIN_W-1:0];
          end
          if (req_i.awaddr == ch_addr(rp_analog_pkg::REG_ADC_OFFS, ch)) begin
            adc_cfg_o[ch].offset <= req_i.wdata[rp_analog_pkg::SAMPLE_W-1:0];
          end
          if (req_i.awaddr == ch_addr(rp_analog_pkg::REG_DAC_GAIN, ch)) begin
            dac_cfg_o[ch].gain <= req_i.wdata[rp_analog_pkg::GAIN_W-1:0];
          end
          if (req_i.awaddr == ch_addr(rp_analog_pkg::REG_DAC_OFFS, ch)) begin
            dac_cfg_o[ch].offset <= req_i.wdata[rp_analog_pkg::SAMPLE_W-1:0];
          end
        end
        for (int ch = 0; ch < PDM_CHN; ch++) begin
          if (req_i.awaddr == ch_addr(rp_analog_pkg::REG_PDM, ch)) begin
            pdm_val_o[ch] <= req_i.wdata[rp_analog_pkg::PDM_W-1:0];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////

  // zero extended read decode
  always_comb begin
    rd_mux = '0;
    if (req_i.araddr == rp_analog_pkg::REG_CTRL) begin
      rd_mux[0] = loop_o;
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (req_i.araddr == ch_addr(rp_analog_pkg::REG_ADC_GAIN, ch)) begin
        rd_mux[rp_analog_pkg::GAIN_W-1:0] = adc_cfg_o[ch].gain;
      end
      if (req_i.araddr == ch_addr(rp_analog_pkg::REG_ADC_OFFS, ch)) begin
        rd_mux[rp_analog_pkg::SAMPLE_W-1:0] = adc_cfg_o[ch].offset;
      end
      if (req_i.araddr == ch_addr(rp_analog_pkg::REG_DAC_GAIN, ch)) begin
        rd_mux[rp_analog_pkg::GAIN_W-1:0] = dac_cfg_o[ch].gain;
      end
      if (req_i.araddr == ch_addr(rp_analog_pkg::REG_DAC_OFFS, ch)) begin
        rd_mux[rp_analog_pkg::SAMPLE_W-1:0] = dac_cfg_o[ch].offset;
      end
    end
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      if (req_i.araddr == ch_addr(rp_analog_pkg::REG_PDM, ch)) begin
        rd_mux[rp_analog_pkg::PDM_W-1:0] = pdm_val_o[ch];
      end
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ar_rdy_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      ar_rdy_q <= req_i.arvalid & ~rvalid_q & ~ar_rdy_q;
      if (rd_en) begin
        rvalid_q <= 1'b1;
      end else if (req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // read data payload
  always_ff @(posedge adc_clk) begin
    if (rd_en) begin
      rdata_q <= rd_mux;
    end
  end

  // response bundle, always OKAY
  assign rsp_o.awready = aw_rdy_q;
  assign rsp_o.wready  = aw_rdy_q;
  assign rsp_o.bvalid  = bvalid_q;
  assign rsp_o.bresp   = 2'b00;
  assign rsp_o.arready = ar_rdy_q;
  assign rsp_o.rvalid  = rvalid_q;
  assign rsp_o.rdata   = rdata_q;
  assign rsp_o.rresp   = 2'b00;

endmodule

//--- rtl/linear_calib.sv
// gain and offset calibration stage
`timescale 1ns/1ns

module linear_calib #(
  parameter type SAMPLE_T = rp_analog_pkg::adc_sample_t
) (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  SAMPLE_T                   sample_i,
  input  rp_analog_pkg::calib_cfg_t cfg_i,
  output SAMPLE_T                   sample_o
);

  localparam int unsigned SW = $bits(SAMPLE_T);
  // full product width
  localparam int unsigned PW = SW + rp_analog_pkg::GAIN_W;

  logic signed [PW-1:0] prod_q;
  logic signed [PW-1:0] shifted;
  logic signed [PW:0]   sum;
  logic        [SW-1:0] sat;

  // stage 1, multiply
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
    end else begin
      prod_q <= $signed(sample_i) * cfg_i.gain;
    end
  end

  // drop gain fraction, add offset
  assign shifted = prod_q >>> rp_analog_pkg::GAIN_FRAC;
  assign sum     = shifted + cfg_i.offset;

  // clamp when upper bits differ from the sign
  always_comb begin
    if (sum[PW:SW-1] != {(PW-SW+2){sum[PW]}}) begin
      sat = sum[PW] ? {1'b1, {(SW-1){1'b0}}} : {1'b0, {(SW-1){1'b1}}};
    end else begin
      sat = sum[SW-1:0];
    end
  end

  // stage 2, saturated result
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sample_o <= '0;
    end else begin
      sample_o <= SAMPLE_T'(sat);
    end
  end

endmodule

//--- rtl/adc_frontend.sv
// ADC input path
`timescale 1ns/1ns

module adc_frontend #(
  parameter int unsigned NUM_CH = 2
) (
  input  logic                                            adc_clk,
  input  logic                                            top_rst,
  input  logic [NUM_CH-1:0][rp_analog_pkg::SAMPLE_W-1:0]  adc_dat_i,
  input  logic                                            loop_i,
  input  rp_analog_pkg::dac_sample_t [NUM_CH-1:0]         loop_dat_i,
  input  rp_analog_pkg::calib_cfg_t  [NUM_CH-1:0]         cfg_i,
  output rp_analog_pkg::adc_sample_t [NUM_CH-1:0]         adc_cal_o
);

  localparam int unsigned SW = rp_analog_pkg::SAMPLE_W;

  rp_analog_pkg::adc_sample_t [NUM_CH-1:0] raw_q;
  rp_analog_pkg::adc_sample_t [NUM_CH-1:0] cal_in;

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch

    // input register, offset binary to signed
    // msb kept, the rest inverted
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        raw_q[ch] <= '0;
      end else begin
        raw_q[ch] <= {adc_dat_i[ch][SW-1], ~adc_dat_i[ch][SW-2:0]};
      end
    end

    // digital loopback mux
    assign cal_in[ch] = loop_i ? rp_analog_pkg::adc_sample_t'(loop_dat_i[ch]) : raw_q[ch];

    linear_calib #(
      .SAMPLE_T (rp_analog_pkg::adc_sample_t)
    ) u_calib (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .sample_i (cal_in[ch]),
      .cfg_i    (cfg_i[ch]),
      .sample_o (adc_cal_o[ch])
    );

  end

endmodule

//--- rtl/dac_backend.sv
// DAC output path
`timescale 1ns/1ns

module dac_backend #(
  parameter int unsigned NUM_CH = 2
) (
  input  logic                                            adc_clk,
  input  logic                                            top_rst,
  input  rp_analog_pkg::dac_sample_t [NUM_CH-1:0]         gen_dat_i,
  input  rp_analog_pkg::calib_cfg_t  [NUM_CH-1:0]         cfg_i,
  output rp_analog_pkg::dac_sample_t [NUM_CH-1:0]         dac_cal_o,
  output logic [NUM_CH-1:0][rp_analog_pkg::SAMPLE_W-1:0]  dac_dat_o
);

  localparam int unsigned SW = rp_analog_pkg::SAMPLE_W;

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch

    // calibrated sample, also feeds loopback
    linear_calib #(
      .SAMPLE_T (rp_analog_pkg::dac_sample_t)
    ) u_calib (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .sample_i (gen_dat_i[ch]),
      .cfg_i    (cfg_i[ch]),
      .sample_o (dac_cal_o[ch])
    );

    // output register
    // inverted offset binary, negative slope converter
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        dac_dat_o[ch] <= '0;
      end else begin
        dac_dat_o[ch] <= {dac_cal_o[ch][SW-1], ~dac_cal_o[ch][SW-2:0]};
      end
    end

  end

endmodule

//--- rtl/pdm_modulator.sv
// first order PDM outputs
`timescale 1ns/1ns

module pdm_modulator #(
  parameter int unsigned PDM_CHN = 4
) (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  input  rp_analog_pkg::pdm_val_t [PDM_CHN-1:0] val_i,
  output logic [PDM_CHN-1:0]                    pdm_o
);

  localparam int unsigned PW = rp_analog_pkg::PDM_W;
  // full scale, 255 for 8 bits
  localparam logic [PW:0] FULL = {1'b0, {PW{1'b1}}};

  // accumulator stays below full scale
  logic [PDM_CHN-1:0][PW-1:0] acc_q;
  logic [PDM_CHN-1:0][PW:0]   sum;

  always_comb begin
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      sum[ch] = {1'b0, acc_q[ch]} + {1'b0, val_i[ch]};
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc_q <= '0;
      pdm_o <= '0;
    end else begin
      for (int ch = 0; ch < PDM_CHN; ch++) begin
        // overflow emits a pulse
        if (sum[ch] >= FULL) begin
          pdm_o[ch] <= 1'b1;
          acc_q[ch] <= PW'(sum[ch] - FULL);
        end else begin
          pdm_o[ch] <= 1'b0;
          acc_q[ch] <= sum[ch][PW-1:0];
        end
      end
    end
  end

endmodule

//--- rtl/rp_analog_top.sv
// analog chain top level
`timescale 1ns/1ns

module rp_analog_top #(
  parameter int unsigned NUM_CH  = 2,
  parameter int unsigned PDM_CHN = 4
) (
  input  logic                                            adc_clk,
  input  logic                                            top_rst,
  input  rp_analog_pkg::axil_req_t                        axil_req_i,
  output rp_analog_pkg::axil_rsp_t                        axil_rsp_o,
  input  logic [NUM_CH-1:0][rp_analog_pkg::SAMPLE_W-1:0]  adc_dat_i,
  input  rp_analog_pkg::dac_sample_t [NUM_CH-1:0]         gen_dat_i,
  output rp_analog_pkg::adc_sample_t [NUM_CH-1:0]         adc_cal_o,
  output logic [NUM_CH-1:0][rp_analog_pkg::SAMPLE_W-1:0]  dac_dat_o,
  output logic [PDM_CHN-1:0]                              pdm_o
);

  ////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////

  rp_analog_pkg::calib_cfg_t [NUM_CH-1:0]  adc_cfg;
  rp_analog_pkg::calib_cfg_t [NUM_CH-1:0]  dac_cfg;
  rp_analog_pkg::pdm_val_t   [PDM_CHN-1:0] pdm_val;
  logic                                    loop_en;
  // calibrated DAC samples for loopback
  rp_analog_pkg::dac_sample_t [NUM_CH-1:0] dac_cal;

  axil_cfg_regs #(
    .NUM_CH  (NUM_CH),
    .PDM_CHN (PDM_CHN)
  ) u_regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .req_i     (axil_req_i),
    .rsp_o     (axil_rsp_o),
    .adc_cfg_o (adc_cfg),
    .dac_cfg_o (dac_cfg),
    .loop_o    (loop_en),
    .pdm_val_o (pdm_val)
  );

  ////////////////////////////////////////////////////////////
  // sample paths
  ////////////////////////////////////////////////////////////

  adc_frontend #(
    .NUM_CH (NUM_CH)
  ) u_adc (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .loop_i     (loop_en),
    .loop_dat_i (dac_cal),
    .cfg_i      (adc_cfg),
    .adc_cal_o  (adc_cal_o)
  );

  dac_backend #(
    .NUM_CH (NUM_CH)
  ) u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_dat_i (gen_dat_i),
    .cfg_i     (dac_cfg),
    .dac_cal_o (dac_cal),
    .dac_dat_o (dac_dat_o)
  );

  // slow analog outputs
  pdm_modulator #(
    .PDM_CHN (PDM_CHN)
  ) u_pdm (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .val_i   (pdm_val),
    .pdm_o   (pdm_o)
  );

endmodule

//--- verification/tb_rp_analog_top.sv
// analog chain testbench
`timescale 1ns/1ns

module tb_rp_analog_top;

  localparam int NUM_CH     = 2;
  localparam int PDM_CHN    = 4;
  localparam int AW         = rp_analog_pkg::AXIL_ADDR_W;
  localparam int SW         = rp_analog_pkg::SAMPLE_W;
  localparam int GW         = rp_analog_pkg::GAIN_W;
  localparam int PW         = rp_analog_pkg::PDM_W;
  localparam longint SMAX   = (longint'(1) << (SW - 1)) - 1;
  localparam longint SMIN   = -SMAX - 1;
  localparam int PDM_FULL   = (1 << PW) - 1;
  // pipeline depths seen from the driving edge
  localparam int ADC_LAT    = 3;
  localparam int LOOP_LAT   = 4;
  localparam int DAC_LAT    = 3;
  localparam int CLK_NS     = 20;
  localparam int STREAM_CYC = 300;
  // reset reads, three calibration loads, ctrl writes, pdm writes
  localparam int AXI_OPS    = 14 + 3 * 8 * 2 + 2 * 2 + PDM_CHN * 2;
  localparam int AXI_CYC    = 6;
  localparam int TOTAL_CYC  = 3 + AXI_OPS * AXI_CYC + 5 * STREAM_CYC + PDM_FULL + 8;
  localparam int TIMEOUT_NS = TOTAL_CYC * CLK_NS + 2000;

  logic                                    adc_clk;
  logic                                    top_rst;
  rp_analog_pkg::axil_req_t                req;
  rp_analog_pkg::axil_rsp_t                rsp;
  logic [NUM_CH-1:0][SW-1:0]               adc_dat;
  rp_analog_pkg::dac_sample_t [NUM_CH-1:0] gen_dat;
  rp_analog_pkg::adc_sample_t [NUM_CH-1:0] adc_cal;
  logic [NUM_CH-1:0][SW-1:0]               dac_dat;
  logic [PDM_CHN-1:0]                      pdm;

  // reference model state
  logic [31:0]        rng;
  logic [GW-1:0]      adc_gain_m [NUM_CH];
  logic [SW-1:0]      adc_offs_m [NUM_CH];
  logic [GW-1:0]      dac_gain_m [NUM_CH];
  logic [SW-1:0]      dac_offs_m [NUM_CH];
  logic               loop_m;
  logic [PW-1:0]      pdm_val_m [PDM_CHN];
  logic [PW-1:0]      pdm_acc_m [PDM_CHN];
  logic [PDM_CHN-1:0] pdm_exp;

  rp_analog_top #(
    .NUM_CH  (NUM_CH),
    .PDM_CHN (PDM_CHN)
  ) DUT (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .axil_req_i (req),
    .axil_rsp_o (rsp),
    .adc_dat_i  (adc_dat),
    .gen_dat_i  (gen_dat),
    .adc_cal_o  (adc_cal),
    .dac_dat_o  (dac_dat),
    .pdm_o      (pdm)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_NS / 2) adc_clk = ~adc_clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before all tests finished");
    $display("Simulation FAILED");
    $fatal(1, "watchdog");
  end

  ////////////////////////////////////////////////////////////
  // model functions
  ////////////////////////////////////////////////////////////

  // xorshift32 step
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // keep msb, invert the rest (both converter formats)
  function automatic logic [SW-1:0] flip_low_bits(input logic [SW-1:0] w);
    logic [SW-1:0] mask;
    mask = (SW'(1) << (SW - 1)) - SW'(1);
    return w ^ mask;
  endfunction

  // sample * gain >>> frac + offset, clamped
  function automatic logic [SW-1:0] calib_model(input logic [SW-1:0] s,
                                                input logic [GW-1:0] gain,
                                                input logic [SW-1:0] offs);
    longint v;
    v = longint'($signed(s)) * longint'($signed(gain));
    v = v >>> rp_analog_pkg::GAIN_FRAC;
    v = v + longint'($signed(offs));
    if (v > SMAX) begin
      v = SMAX;
    end else if (v < SMIN) begin
      v = SMIN;
    end
    return v[SW-1:0];
  endfunction

  function automatic logic [AW-1:0] chan_addr(input logic [AW-1:0] base, input int ch);
    return base + AW'(4 * ch);
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("Mismatch %s expected 0x%0h actual 0x%0h", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // first order accumulator, steps with the DUT edge
  always @(posedge adc_clk) begin : pdm_ref
    int sum;
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      sum = pdm_acc_m[ch] + pdm_val_m[ch];
      if (top_rst) begin
        pdm_acc_m[ch] <= '0;
        pdm_exp[ch]   <= 1'b0;
      end else if (sum >= PDM_FULL) begin
        pdm_acc_m[ch] <= PW'(sum - PDM_FULL);
        pdm_exp[ch]   <= 1'b1;
      end else begin
        pdm_acc_m[ch] <= PW'(sum);
        pdm_exp[ch]   <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // AXI4-Lite access
  ////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [AW-1:0] addr, input logic [31:0] data);
    @(posedge adc_clk);
    req.awaddr  <= addr;
    req.awvalid <= 1'b1;
    req.wdata   <= data;
    req.wvalid  <= 1'b1;
    req.bready  <= 1'b1;
    do begin
      @(negedge adc_clk);
    end while (!rsp.awready);
    // address and data ready rise together
    check_val("write wready", 32'd1, 32'(rsp.wready));
    // handshake edge
    @(posedge adc_clk);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    // pdm mirror acts from the next edge, like the register
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      if (addr == chan_addr(rp_analog_pkg::REG_PDM, ch)) begin
        pdm_val_m[ch] <= data[PW-1:0];
      end
    end
    do begin
      @(negedge adc_clk);
    end while (!rsp.bvalid);
    check_val("write bresp", 32'd0, 32'(rsp.bresp));
    @(posedge adc_clk);
    req.bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [AW-1:0] addr, output logic [31:0] data);
    @(posedge adc_clk);
    req.araddr  <= addr;
    req.arvalid <= 1'b1;
    req.rready  <= 1'b1;
    do begin
      @(negedge adc_clk);
    end while (!rsp.arready);
    @(posedge adc_clk);
    req.arvalid <= 1'b0;
    do begin
      @(negedge adc_clk);
    end while (!rsp.rvalid);
    data = rsp.rdata;
    check_val("read rresp", 32'd0, 32'(rsp.rresp));
    @(posedge adc_clk);
    req.rready <= 1'b0;
  endtask

  task automatic expect_reg(input logic [AW-1:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    read_reg(addr, rd);
    check_val(name, exp, rd);
  endtask

  // readback is the low bits, zero extended
  task automatic write_verify(input logic [AW-1:0] addr, input logic [31:0] data,
                              input int width, input string name);
    logic [31:0] mask;
    mask = (32'd1 << width) - 1;
    write_reg(addr, data);
    expect_reg(addr, data & mask, name);
  endtask

  ////////////////////////////////////////////////////////////
  // test steps
  ////////////////////////////////////////////////////////////

  // random calibration, or full scale gains of both signs
  task automatic load_calib(input bit extreme);
    logic [31:0] ag;
    logic [31:0] ao;
    logic [31:0] dg;
    logic [31:0] dofs;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      ag   = next_rand();
      ao   = next_rand();
      dg   = next_rand();
      dofs = next_rand();
      if (extreme) begin
        ag[GW-1:0] = (ch % 2) ? 16'h8000 : 16'h7fff;
        dg[GW-1:0] = (ch % 2) ? 16'h7fff : 16'h8000;
      end
      write_verify(chan_addr(rp_analog_pkg::REG_ADC_GAIN, ch), ag, GW, "adc gain readback");
      write_verify(chan_addr(rp_analog_pkg::REG_ADC_OFFS, ch), ao, SW, "adc offs readback");
      write_verify(chan_addr(rp_analog_pkg::REG_DAC_GAIN, ch), dg, GW, "dac gain readback");
      write_verify(chan_addr(rp_analog_pkg::REG_DAC_OFFS, ch), dofs, SW, "dac offs readback");
      adc_gain_m[ch] = ag[GW-1:0];
      adc_offs_m[ch] = ao[SW-1:0];
      dac_gain_m[ch] = dg[GW-1:0];
      dac_offs_m[ch] = dofs[SW-1:0];
    end
  endtask

  // random samples on both paths, outputs checked at the falling edge
  task automatic run_stream(input string name);
    logic [NUM_CH-1:0][SW-1:0] adc_nxt;
    logic [NUM_CH-1:0][SW-1:0] gen_nxt;
    logic [NUM_CH-1:0][SW-1:0] adc_exp;
    logic [NUM_CH-1:0][SW-1:0] dac_exp;
    logic [NUM_CH-1:0][SW-1:0] old;
    logic [NUM_CH-1:0][SW-1:0] adc_q [$];
    logic [NUM_CH-1:0][SW-1:0] dac_q [$];
    logic [SW-1:0]             dac_c;
    int                        lat;
    lat = loop_m ? LOOP_LAT : ADC_LAT;
    for (int i = 0; i < STREAM_CYC; i++) begin
      @(posedge adc_clk);
      for (int ch = 0; ch < NUM_CH; ch++) begin
        adc_nxt[ch] = SW'(next_rand());
        gen_nxt[ch] = SW'(next_rand());
        dac_c       = calib_model(gen_nxt[ch], dac_gain_m[ch], dac_offs_m[ch]);
        dac_exp[ch] = flip_low_bits(dac_c);
        // loopback bypasses the converter word
        adc_exp[ch] = calib_model(loop_m ? dac_c : flip_low_bits(adc_nxt[ch]),
                                  adc_gain_m[ch], adc_offs_m[ch]);
      end
      adc_dat <= adc_nxt;
      gen_dat <= gen_nxt;
      adc_q.push_back(adc_exp);
      dac_q.push_back(dac_exp);
      @(negedge adc_clk);
      if (adc_q.size() > lat) begin
        old = adc_q.pop_front();
        for (int ch = 0; ch < NUM_CH; ch++) begin
          check_val({name, " adc_cal_o"}, 32'(old[ch]), 32'($unsigned(adc_cal[ch])));
        end
      end
      if (dac_q.size() > DAC_LAT) begin
        old = dac_q.pop_front();
        for (int ch = 0; ch < NUM_CH; ch++) begin
          check_val({name, " dac_dat_o"}, 32'(old[ch]), 32'(dac_dat[ch]));
        end
      end
    end
  endtask

  task automatic pdm_test();
    logic [31:0] v;
    int          ones [PDM_CHN];
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      v = next_rand();
      // top channel at full scale
      if (ch == PDM_CHN - 1) begin
        v[PW-1:0] = '1;
      end
      write_verify(chan_addr(rp_analog_pkg::REG_PDM, ch), v, PW, "pdm readback");
    end
    repeat (2) @(posedge adc_clk);
    ones = '{default: 0};
    for (int i = 0; i < PDM_FULL; i++) begin
      @(negedge adc_clk);
      check_val("pdm bit sequence", 32'(pdm_exp), 32'(pdm));
      for (int ch = 0; ch < PDM_CHN; ch++) begin
        ones[ch] += pdm[ch];
      end
    end
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      check_val("pdm ones per window", 32'(pdm_val_m[ch]), ones[ch]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rng     = 32'h92ea006d;
    top_rst = 1'b1;
    req     = '0;
    adc_dat = '0;
    gen_dat = '0;
    loop_m  = 1'b0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      adc_gain_m[ch] = rp_analog_pkg::GAIN_ONE;
      adc_offs_m[ch] = '0;
      dac_gain_m[ch] = rp_analog_pkg::GAIN_ONE;
      dac_offs_m[ch] = '0;
    end
    pdm_val_m = '{default: '0};
    repeat (3) @(posedge adc_clk);
    top_rst <= 1'b0;
    // outputs still cleared from the last reset edge
    @(negedge adc_clk);
    check_val("reset adc_cal_o", 32'd0, 32'(adc_cal));
    check_val("reset dac_dat_o", 32'd0, 32'(dac_dat));
    check_val("reset pdm_o", 32'd0, 32'(pdm));
    check_val("reset bus flags", 32'd0,
              32'({rsp.awready, rsp.wready, rsp.bvalid, rsp.arready, rsp.rvalid}));
    // register reset values
    expect_reg(rp_analog_pkg::REG_CTRL, 32'd0, "reset ctrl");
    for (int ch = 0; ch < NUM_CH; ch++) begin
      expect_reg(chan_addr(rp_analog_pkg::REG_ADC_GAIN, ch), 32'd16384, "reset adc gain");
      expect_reg(chan_addr(rp_analog_pkg::REG_ADC_OFFS, ch), 32'd0, "reset adc offs");
      expect_reg(chan_addr(rp_analog_pkg::REG_DAC_GAIN, ch), 32'd16384, "reset dac gain");
      expect_reg(chan_addr(rp_analog_pkg::REG_DAC_OFFS, ch), 32'd0, "reset dac offs");
    end
    for (int ch = 0; ch < PDM_CHN; ch++) begin
      expect_reg(chan_addr(rp_analog_pkg::REG_PDM, ch), 32'd0, "reset pdm");
    end
    expect_reg(8'h40, 32'd0, "unmapped read");
    load_calib(1'b0);
    run_stream("adc calibration");
    load_calib(1'b1);
    run_stream("saturation");
    load_calib(1'b0);
    run_stream("dac path");
    write_verify(rp_analog_pkg::REG_CTRL, 32'd1, 1, "ctrl loopback on");
    loop_m = 1'b1;
    run_stream("loopback on");
    write_verify(rp_analog_pkg::REG_CTRL, 32'd0, 1, "ctrl loopback off");
    loop_m = 1'b0;
    run_stream("loopback off");
    pdm_test();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- rp_analog_top.f
rtl/rp_analog_pkg.sv
rtl/axil_cfg_regs.sv
rtl/linear_calib.sv
rtl/adc_frontend.sv
rtl/dac_backend.sv
rtl/pdm_modulator.sv
rtl/rp_analog_top.sv
verification/tb_rp_analog_top.sv

//--- Bender.yml
package:
  name: rp_analog

sources:
  - rtl/rp_analog_pkg.sv
  - rtl/axil_cfg_regs.sv
  - rtl/linear_calib.sv
  - rtl/adc_frontend.sv
  - rtl/dac_backend.sv
  - rtl/pdm_modulator.sv
  - rtl/rp_analog_top.sv
  - target: test
    files:
      - verification/tb_rp_analog_top.sv
